//--- verilog/gmii_video_pkg.sv
`default_nettype none

package gmii_video_pkg;

	// Frame filter values.
	localparam logic [15:0] eth_type_video = 16'h0800; // IPv4.
	localparam logic [7:0]  ip_ver_ihl     = 8'h45;    // Version 4 without options.
	localparam logic [7:0]  ip_proto_udp   = 8'h11;
	localparam logic [31:0] ipv4_dst_local = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [15:0] udp_dst_video  = 16'd12345;

	// Byte offsets, counted from the first preamble byte.
	localparam logic [10:0] off_eth_type = 11'd20;
	localparam logic [10:0] off_ip_ver   = 11'd22;
	localparam logic [10:0] off_ip_proto = 11'd31;
	localparam logic [10:0] off_ip_dst   = 11'd38;
	localparam logic [10:0] off_udp_dst  = 11'd44;
	localparam logic [10:0] off_payload  = 11'd50;
	localparam logic [10:0] off_last     = 11'd1331; // Last byte of the last pixel pair.

	localparam int max_words = 640;

	// FIFO address widths.
	localparam int pix_fifo_aw = 10;
	localparam int rpt_fifo_aw = 4;

	typedef struct packed {
		logic        rsvd;    // Always zero.
		logic        col_lsb;
		logic [10:0] line;
		logic [7:0]  pix_hi;  // Earlier byte of the pair.
		logic [7:0]  pix_lo;
	} pixel_word_t;

	typedef struct packed {
		logic [10:0] line;
		logic        col_lsb;
		logic [9:0]  word_count;
	} line_report_t;

endpackage

`default_nettype wire

//--- verilog/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  aw        = 4
) (
	input  wire      clk125,
	input  wire      sys_rst,
	input  wire      wr,
	input  payload_t din,
	input  wire      rd,
	output payload_t dout,
	output logic     empty,
	output logic     overflow
);

	payload_t       mem [2**aw];
	logic [aw-1:0]  wr_ptr;
	logic [aw-1:0]  rd_ptr;
	logic [aw:0]    count;   // Occupancy, 0 to 2**aw.
	logic           full;
	logic           do_wr;
	logic           do_rd;

	assign full  = count[aw];
	assign empty = (count == '0);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty; // Reads while empty are ignored.

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
			if (wr && full)
				overflow <= 1'b1; // Sticky until reset.
		end
	end

	// Storage and registered read port.
	always_ff @(posedge clk125) begin
		if (do_wr)
			mem[wr_ptr] <= din;
		if (do_rd)
			dout <= mem[rd_ptr]; // Holds until the next read.
	end

endmodule

`default_nettype wire

//--- verilog/udp_video_rx.sv
`timescale 1ns/100ps
`default_nettype none

module udp_video_rx import gmii_video_pkg::*; (
	input  wire         clk125,
	input  wire         sys_rst,
	input  wire  [7:0]  rxd,
	input  wire         rx_dv,
	output pixel_word_t pix_word,
	output logic        pix_valid,
	output logic        packet_active
);

	typedef enum logic {
		pk_hi_byte,
		pk_lo_byte
	} pk_state_t;

	logic [10:0] rx_count;
	logic [15:0] eth_type;
	logic [7:0]  ip_ver;
	logic [7:0]  ip_proto;
	logic [31:0] ip_dst;
	logic [15:0] udp_dst;
	logic        hdr_match;

	logic [10:0] line_num;
	logic        col_lsb;
	logic [7:0]  pix_hi;
	pk_state_t   pk_state;
	logic        pix_byte;

	assign hdr_match = (eth_type == eth_type_video) &&
		(ip_ver == ip_ver_ihl) &&
		(ip_proto == ip_proto_udp) &&
		(ip_dst == ipv4_dst_local) &&
		(udp_dst == udp_dst_video);

	// Pixel bytes start after the line/column pair.
	assign pix_byte = rx_dv && packet_active && (rx_count > off_payload + 11'd1);

	// Byte counter and header capture.
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			rx_count      <= '0;
			eth_type      <= '0;
			ip_ver        <= '0;
			ip_proto      <= '0;
			ip_dst        <= '0;
			udp_dst       <= '0;
			packet_active <= 1'b0;
		end else if (!rx_dv) begin
			rx_count      <= '0; // Gap between frames.
			eth_type      <= '0;
			ip_ver        <= '0;
			ip_proto      <= '0;
			ip_dst        <= '0;
			udp_dst       <= '0;
			packet_active <= 1'b0;
		end else begin
			if (rx_count != '1)
				rx_count <= rx_count + 11'd1; // Saturates on very long frames.
			case (rx_count)
				off_eth_type:          eth_type[15:8] <= rxd;
				off_eth_type + 11'd1:  eth_type[7:0]  <= rxd;
				off_ip_ver:            ip_ver         <= rxd;
				off_ip_proto:          ip_proto       <= rxd;
				off_ip_dst:            ip_dst[31:24]  <= rxd;
				off_ip_dst + 11'd1:    ip_dst[23:16]  <= rxd;
				off_ip_dst + 11'd2:    ip_dst[15:8]   <= rxd;
				off_ip_dst + 11'd3:    ip_dst[7:0]    <= rxd;
				off_udp_dst:           udp_dst[15:8]  <= rxd;
				off_udp_dst + 11'd1:   udp_dst[7:0]   <= rxd;
				off_payload:           packet_active  <= hdr_match; // Frame decision.
				off_last:              packet_active  <= 1'b0;      // Truncate at max_words.
				default: ;
			endcase
		end
	end

	// Line number and column tag from the first two payload bytes.
	always_ff @(posedge clk125) begin
		if (rx_dv && rx_count == off_payload)
			line_num[7:0] <= rxd;
		if (rx_dv && rx_count == off_payload + 11'd1) begin
			line_num[10:8] <= rxd[2:0];
			col_lsb        <= rxd[4];   // Bit 0 of the column tag.
		end
	end

	// Strobe side of the two-state packer.
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			pk_state  <= pk_hi_byte;
			pix_valid <= 1'b0;
		end else if (!rx_dv) begin
			pk_state  <= pk_hi_byte; // An odd trailing byte is dropped here.
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= 1'b0;
			if (pix_byte) begin
				case (pk_state)
					pk_hi_byte: pk_state <= pk_lo_byte;
					pk_lo_byte: begin
						pk_state  <= pk_hi_byte;
						pix_valid <= 1'b1;
					end
					default: pk_state <= pk_hi_byte;
				endcase
			end
		end
	end

	// Packer data path.
	always_ff @(posedge clk125) begin
		if (pix_byte) begin
			if (pk_state == pk_hi_byte) begin
				pix_hi <= rxd;
			end else begin
				pix_word <= '{
					rsvd:    1'b0,
					col_lsb: col_lsb,
					line:    line_num,
					pix_hi:  pix_hi,
					pix_lo:  rxd
				};
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/line_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module line_tracker import gmii_video_pkg::*; (
	input  wire          clk125,
	input  wire          sys_rst,
	input  pixel_word_t  pix_word,
	input  wire          pix_valid,
	input  wire          packet_active,
	output line_report_t report,
	output logic         report_valid
);

	logic [9:0]  word_count;
	logic [10:0] last_line;
	logic        last_col_lsb;

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			word_count   <= '0;
			last_line    <= '0;
			last_col_lsb <= 1'b0;
			report       <= '0;
			report_valid <= 1'b0;
		end else begin
			report_valid <= 1'b0;
			if (pix_valid) begin
				word_count   <= word_count + 10'd1;
				last_line    <= pix_word.line;
				last_col_lsb <= pix_word.col_lsb;
			end else if (!packet_active && word_count != '0) begin
				report <= '{
					line:       last_line,
					col_lsb:    last_col_lsb,
					word_count: word_count
				};
				report_valid <= 1'b1;
				word_count   <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/gmii_video_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module gmii_video_rx_top import gmii_video_pkg::*; (
	input  wire          clk125,
	input  wire          sys_rst,
	input  wire  [7:0]   rxd,
	input  wire          rx_dv,
	input  wire          pix_rd,
	output pixel_word_t  pix_dout,
	output logic         pix_empty,
	output logic         pix_overflow,
	input  wire          rpt_rd,
	output line_report_t rpt_dout,
	output logic         rpt_empty,
	output logic         rpt_overflow,
	output logic         packet_active
);

	pixel_word_t  pix_word;
	logic         pix_valid;
	line_report_t report;
	logic         report_valid;

	udp_video_rx u_rx (
		.clk125        (clk125),
		.sys_rst       (sys_rst),
		.rxd           (rxd),
		.rx_dv         (rx_dv),
		.pix_word      (pix_word),
		.pix_valid     (pix_valid),
		.packet_active (packet_active)
	);

	line_tracker u_tracker (
		.clk125        (clk125),
		.sys_rst       (sys_rst),
		.pix_word      (pix_word),
		.pix_valid     (pix_valid),
		.packet_active (packet_active),
		.report        (report),
		.report_valid  (report_valid)
	);

	// Pixel words for the consumer.
	sync_fifo #(
		.payload_t (pixel_word_t),
		.aw        (pix_fifo_aw)
	) u_pix_fifo (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr       (pix_valid),
		.din      (pix_word),
		.rd       (pix_rd),
		.dout     (pix_dout),
		.empty    (pix_empty),
		.overflow (pix_overflow)
	);

	// One report per accepted line.
	sync_fifo #(
		.payload_t (line_report_t),
		.aw        (rpt_fifo_aw)
	) u_rpt_fifo (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr       (report_valid),
		.din      (report),
		.rd       (rpt_rd),
		.dout     (rpt_dout),
		.empty    (rpt_empty),
		.overflow (rpt_overflow)
	);

endmodule

`default_nettype wire

//--- tests/tb_frame_tasks.svh
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// A frame passes the filter only when all five header fields match.
function automatic logic frame_accepted(input frame_row_t row);
	return (row.eth_type == eth_type_video) && (row.ip_ver == ip_ver_ihl) &&
		(row.proto == ip_proto_udp) && (row.ip_dst == ipv4_dst_local) &&
		(row.udp_dst == udp_dst_video);
endfunction

task automatic drive_byte(input logic [7:0] b);
	rxd   = b;
	rx_dv = 1'b1;
	@(posedge clk125);
	#2;
endtask

task automatic idle_cycles(input int n);
	rxd   = 8'h00;
	rx_dv = 1'b0;
	repeat (n) begin
		@(posedge clk125);
		#2;
	end
endtask

task automatic push16(input logic [15:0] v);
	frame_q.push_back(v[15:8]); // Network byte order.
	frame_q.push_back(v[7:0]);
endtask

// Pixel words pair up payload bytes 2 and 3, 4 and 5, and so on.
task automatic expect_frame(input frame_row_t row);
	int           nwords;
	pixel_word_t  w;
	line_report_t r;
	nwords = (int'(row.len) - 2) / 2;
	if (nwords > max_words)
		nwords = max_words; // Longer payloads are cut.
	for (int i = 0; i < nwords; i++) begin
		w.rsvd    = 1'b0;
		w.col_lsb = row.col[0];
		w.line    = row.line[10:0];
		w.pix_hi  = payload_q[2 + 2 * i];
		w.pix_lo  = payload_q[3 + 2 * i];
		exp_pix.push_back(w);
	end
	if (nwords > 0) begin
		r.line       = row.line[10:0];
		r.col_lsb    = row.col[0];
		r.word_count = 10'(nwords);
		exp_rpt.push_back(r);
	end
endtask

// Preamble, Ethernet, IPv4 and UDP headers, payload, then the gap.
task automatic send_frame(input frame_row_t row);
	logic accept;
	accept = frame_accepted(row);
	payload_q.delete();
	payload_q.push_back(row.line[7:0]);
	payload_q.push_back({row.col, row.line[11:8]});
	for (int i = 2; i < int'(row.len); i++)
		payload_q.push_back(8'($urandom()));
	frame_q.delete();
	repeat (7)
		frame_q.push_back(8'h55);
	frame_q.push_back(8'hd5); // SFD.
	for (int i = 0; i < 12; i++)
		frame_q.push_back(8'h10 + 8'(i)); // Destination and source MAC.
	push16(row.eth_type);
	frame_q.push_back(row.ip_ver);
	frame_q.push_back(8'h00);
	push16(16'(28 + int'(row.len))); // IP total length.
	push16(16'h1c46);
	push16(16'h4000);
	frame_q.push_back(8'h40); // TTL.
	frame_q.push_back(row.proto);
	push16(16'h0000);
	push16(16'hc0a8);
	push16(16'h0002);
	push16(row.ip_dst[31:16]);
	push16(row.ip_dst[15:0]);
	push16(16'd5004);
	push16(row.udp_dst);
	push16(16'(8 + int'(row.len))); // UDP length.
	push16(16'h0000);
	foreach (payload_q[i])
		frame_q.push_back(payload_q[i]);
	foreach (frame_q[i]) begin
		drive_byte(frame_q[i]);
		if (i == int'(off_payload)) begin
			check_count++;
			assert (packet_active == accept) else begin
				$display("ERR %0t: packet_active is %0b after payload byte 0, expected %0b",
					$time, packet_active, accept);
				err_count++;
			end
		end
	end
	if (accept)
		expect_frame(row);
	idle_cycles(12);
	check_count++;
	assert (packet_active == 1'b0) else begin
		$display("ERR %0t: packet_active still high in the gap after a frame", $time);
		err_count++;
	end
endtask

`endif

//--- tests/tb_gmii_video_rx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gmii_video_rx import gmii_video_pkg::*; ();

	typedef struct packed {
		logic [15:0] eth_type;
		logic [7:0]  ip_ver;
		logic [7:0]  proto;
		logic [31:0] ip_dst;
		logic [15:0] udp_dst;
		logic [11:0] line;
		logic [3:0]  col;
		logic [10:0] len;     // Payload bytes.
		logic        drain;   // Empty both FIFOs after this frame.
	} frame_row_t;

	logic         clk125;
	logic         sys_rst;
	logic [7:0]   rxd;
	logic         rx_dv;
	logic         pix_rd;
	pixel_word_t  pix_dout;
	logic         pix_empty;
	logic         pix_overflow;
	logic         rpt_rd;
	line_report_t rpt_dout;
	logic         rpt_empty;
	logic         rpt_overflow;
	logic         packet_active;

	frame_row_t   frame_table [14];
	string        test_name [14];
	logic [7:0]   frame_q [$];
	logic [7:0]   payload_q [$];
	pixel_word_t  exp_pix [$];
	line_report_t exp_rpt [$];
	int           err_count = 0;
	int           check_count = 0;
	int           cycle_count = 0;

	gmii_video_rx_top u_dut (
		.clk125        (clk125),
		.sys_rst       (sys_rst),
		.rxd           (rxd),
		.rx_dv         (rx_dv),
		.pix_rd        (pix_rd),
		.pix_dout      (pix_dout),
		.pix_empty     (pix_empty),
		.pix_overflow  (pix_overflow),
		.rpt_rd        (rpt_rd),
		.rpt_dout      (rpt_dout),
		.rpt_empty     (rpt_empty),
		.rpt_overflow  (rpt_overflow),
		.packet_active (packet_active)
	);

	`include "tb_frame_tasks.svh"

	initial begin
		clk125 = 1'b0;
		forever #10 clk125 = ~clk125;
	end

	// Room for the longest frame plus a full drain per row.
	initial begin
		while (cycle_count < $size(frame_table) * 2100 + 100) begin
			@(posedge clk125);
			cycle_count++;
		end
		$display("Timeout: the run hung after %0d cycles.", cycle_count);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic frame_row_t good_row(input logic [11:0] line, input logic [3:0] col,
		input int len, input logic drain);
		frame_row_t row;
		row.eth_type = eth_type_video;
		row.ip_ver   = ip_ver_ihl;
		row.proto    = ip_proto_udp;
		row.ip_dst   = ipv4_dst_local;
		row.udp_dst  = udp_dst_video;
		row.line     = line;
		row.col      = col;
		row.len      = 11'(len);
		row.drain    = drain;
		return row;
	endfunction

	task automatic load_table();
		frame_table[0] = good_row(12'h005, 4'h3, 100, 1'b1);
		test_name[0]   = "even payload";
		for (int i = 1; i <= 5; i++)
			frame_table[i] = good_row(12'h010 + 12'(i), 4'h1, 40, 1'b1);
		frame_table[1].eth_type = 16'h86dd;
		test_name[1]   = "bad ethertype";
		frame_table[2].ip_ver = 8'h46;
		test_name[2]   = "bad version";
		frame_table[3].proto = 8'h06;
		test_name[3]   = "bad protocol";
		frame_table[4].ip_dst = {8'd192, 8'd168, 8'd0, 8'd2};
		test_name[4]   = "bad address";
		frame_table[5].udp_dst = 16'd12346;
		test_name[5]   = "bad port";
		frame_table[6] = good_row(12'hfa3, 4'he, 51, 1'b1); // Line bit 11 is not kept.
		test_name[6]   = "odd payload";
		frame_table[7] = good_row(12'h123, 4'h5, 1400, 1'b1);
		test_name[7]   = "truncated";
		frame_table[8] = good_row(12'd100, 4'h2, 64, 1'b0);
		frame_table[9] = good_row(12'd200, 4'h7, 30, 1'b0);
		frame_table[10] = good_row(12'd300, 4'h8, 20, 1'b1);
		for (int i = 11; i <= 13; i++)
			frame_table[i] = good_row(12'd389 + 12'(i), 4'h9, 1400, i == 13);
		for (int i = 8; i <= 10; i++)
			test_name[i] = "back to back";
		for (int i = 11; i <= 13; i++)
			test_name[i] = "pixel overflow";
	endtask

	// Only the first words up to the FIFO depth survive; the rest set overflow.
	task automatic drain_pixels();
		int          n_read;
		int          n_keep;
		logic        exp_ovf;
		pixel_word_t want;
		exp_ovf = (exp_pix.size() > 2 ** pix_fifo_aw);
		n_keep  = exp_ovf ? 2 ** pix_fifo_aw : exp_pix.size();
		n_read  = 0;
		while (!pix_empty) begin
			pix_rd = 1'b1;
			@(posedge clk125);
			#2;
			pix_rd = 1'b0;
			want = (n_read < n_keep) ? exp_pix[n_read] : '0;
			check_count++;
			assert (n_read < n_keep && pix_dout == want) else begin
				$display("ERR %0t: pixel word %0d is 0x%08h, expected 0x%08h",
					$time, n_read, pix_dout, want);
				err_count++;
			end
			n_read++;
		end
		check_count++;
		assert (n_read == n_keep) else begin
			$display("ERR %0t: read %0d pixel words, expected %0d", $time, n_read, n_keep);
			err_count++;
		end
		check_count++;
		assert (pix_overflow == exp_ovf) else begin
			$display("ERR %0t: pix_overflow is %0b, expected %0b", $time, pix_overflow, exp_ovf);
			err_count++;
		end
		exp_pix.delete();
	endtask

	task automatic drain_reports();
		int           n_read;
		int           n_keep;
		logic         exp_ovf;
		line_report_t want;
		exp_ovf = (exp_rpt.size() > 2 ** rpt_fifo_aw);
		n_keep  = exp_ovf ? 2 ** rpt_fifo_aw : exp_rpt.size();
		n_read  = 0;
		while (!rpt_empty) begin
			rpt_rd = 1'b1;
			@(posedge clk125);
			#2;
			rpt_rd = 1'b0;
			want = (n_read < n_keep) ? exp_rpt[n_read] : '0;
			check_count++;
			assert (n_read < n_keep && rpt_dout == want) else begin
				$display("ERR %0t: report %0d is 0x%06h, expected 0x%06h",
					$time, n_read, rpt_dout, want);
				err_count++;
			end
			n_read++;
		end
		check_count++;
		assert (n_read == n_keep && rpt_overflow == exp_ovf) else begin
			$display("ERR %0t: read %0d reports with overflow %0b, expected %0d with %0b",
				$time, n_read, rpt_overflow, n_keep, exp_ovf);
			err_count++;
		end
		exp_rpt.delete();
	endtask

	initial begin
		int err_before;
		void'($urandom(32'h1d83_82be));
		sys_rst = 1'b1;
		rxd     = 8'h00;
		rx_dv   = 1'b0;
		pix_rd  = 1'b0;
		rpt_rd  = 1'b0;
		load_table();
		repeat (3) @(posedge clk125);
		#2;
		sys_rst = 1'b0;
		@(posedge clk125);
		#2;
		check_count++;
		assert (!packet_active && pix_empty && rpt_empty && !pix_overflow && !rpt_overflow)
		else begin
			$display("ERR %0t: outputs not idle after reset", $time);
			err_count++;
		end
		foreach (frame_table[i]) begin
			err_before = err_count;
			send_frame(frame_table[i]);
			if (frame_table[i].drain) begin
				drain_pixels();
				drain_reports();
			end
			$display("test %0d %s: %0d errors", i, test_name[i], err_count - err_before);
		end
		$display("%0d tests, %0d checks, %0d errors", $size(frame_table), check_count,
			err_count);
		if (err_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tests
verilog/gmii_video_pkg.sv
verilog/sync_fifo.sv
verilog/udp_video_rx.sv
verilog/line_tracker.sv
verilog/gmii_video_rx_top.sv
tests/tb_gmii_video_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the GMII video receiver testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module tb_gmii_video_rx \
	-Mdir obj_dir \
	&& ./obj_dir/Vtb_gmii_video_rx | tee /dev/stderr | grep -qF -- '*** PASSED ***' \
	&& echo "Simulation passed." \
	|| { echo "Simulation did not pass."; exit 1; }
